//--- cluster_config.svh
/*
 * Cluster sizing and DMA beat parameters.
 * Include this wherever a group count or a DMA width is needed.
 */

`ifndef CLUSTER_CONFIG_SVH
`define CLUSTER_CONFIG_SVH

// 2x2 arrangement of groups
`define NUM_GROUPS 4

// Wake-up width is NUM_GROUPS * NUM_CORES_PER_GROUP
`define NUM_CORES_PER_GROUP 4

// Bytes moved by the group DMA engine per cycle
`define DMA_BEAT_BYTES 4

// Width of the num_bytes field in a DMA request
`define DMA_LEN_W 16

`endif

//--- cluster_ctrl_sync.sv
/*
 * Edge registers of the cluster: wake-up lines, the per-group copies of the
 * read-only cache configuration and the DMA status words. One cycle each way.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cluster_config.svh"

module cluster_ctrl_sync (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_i,
  input  wire logic [`NUM_GROUPS*`NUM_CORES_PER_GROUP-1:0]   wake_up_i,
  input  wire cluster_pkg::ro_cache_ctrl_t                   ro_cache_ctrl_i,
  input  wire dma_pkg::dma_meta_t [`NUM_GROUPS-1:0]          dma_meta_i,
  output logic [`NUM_GROUPS*`NUM_CORES_PER_GROUP-1:0]        wake_up_o,
  output cluster_pkg::ro_cache_ctrl_t [`NUM_GROUPS-1:0]      ro_cache_ctrl_o,
  output dma_pkg::dma_meta_t [`NUM_GROUPS-1:0]               dma_meta_o
);

  localparam dma_pkg::dma_meta_t META_RESET = '{
    backend_idle:   1'b1,
    trans_complete: 1'b0
  };

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wake_up_o  <= '0;
      dma_meta_o <= {`NUM_GROUPS{META_RESET}};
    end else begin
      wake_up_o  <= wake_up_i;
      dma_meta_o <= dma_meta_i;
    end
  end

  // Each group gets its own local copy of the cache configuration
  for (genvar g = 0; g < `NUM_GROUPS; g++) begin : gen_ro_cache_ctrl
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        ro_cache_ctrl_o[g] <= cluster_pkg::ro_cache_ctrl_default;
      end else begin
        ro_cache_ctrl_o[g] <= ro_cache_ctrl_i;
      end
    end

    if (g > 0) begin : gen_copy_check
      a_copies_agree: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !$past(rst_i) |-> (ro_cache_ctrl_o[g] == ro_cache_ctrl_o[0])
      ) else $error("Cache control copy of group %0d differs from group 0", g);
    end
  end : gen_ro_cache_ctrl

endmodule : cluster_ctrl_sync

`default_nettype wire

//--- cluster_pkg.sv
/*
 * Cluster-level control types shared by the edge registers and the testbench.
 */

`default_nettype none

package cluster_pkg;

  // Read-only cache configuration, replicated to every group
  typedef struct packed {
    logic enable;
    logic flush;
  } ro_cache_ctrl_t;

  // Value held by every group copy during reset
  localparam ro_cache_ctrl_t ro_cache_ctrl_default = '{
    enable: 1'b1,
    flush:  1'b0
  };

endpackage : cluster_pkg

`default_nettype wire

//--- dma_pkg.sv
/*
 * DMA request and status types, plus the state encoding of the group DMA engine.
 */

`default_nettype none

`include "cluster_config.svh"

package dma_pkg;

  typedef struct packed {
    logic [31:0]            src_addr;
    logic [31:0]            dst_addr;
    logic [`DMA_LEN_W-1:0]  num_bytes;
  } dma_req_t;

  // Status word per group, backend_idle is the upper bit
  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } dma_meta_t;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_BUSY,
    DMA_DONE
  } dma_state_e;

endpackage : dma_pkg

`default_nettype wire

//--- dma_spill_register.sv
/*
 * Two-entry valid/ready spill register for one group's DMA requests.
 * Output data and ready are both taken from flops, so the path is fully cut.
 */

`timescale 1ns/100ps
`default_nettype none

module dma_spill_register (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire dma_pkg::dma_req_t data_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  output dma_pkg::dma_req_t     data_o,
  output logic                  valid_o,
  input  wire logic             ready_i
);

  // Main slot takes new requests, spill slot holds one under back-pressure
  dma_pkg::dma_req_t main_data_q;
  dma_pkg::dma_req_t spill_data_q;
  logic              main_full_q;
  logic              spill_full_q;

  logic main_fill;
  logic main_drain;
  logic spill_fill;
  logic spill_drain;

  assign main_fill   = valid_i && ready_o;
  // Main moves on whenever the spill slot is empty
  assign main_drain  = main_full_q && !spill_full_q;
  assign spill_fill  = main_drain && !ready_i;
  assign spill_drain = spill_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (main_fill || main_drain) begin
        main_full_q <= main_fill;
      end
      if (spill_fill || spill_drain) begin
        spill_full_q <= spill_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_fill) begin
      main_data_q <= data_i;
    end
    if (spill_fill) begin
      spill_data_q <= main_data_q;
    end
  end

  // Older entry sits in the spill slot when both are full
  assign valid_o = main_full_q || spill_full_q;
  assign data_o  = spill_full_q ? spill_data_q : main_data_q;
  assign ready_o = !main_full_q || !spill_full_q;

  // Upstream must hold its request while stalled
  a_stable_while_stalled: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (valid_i && !ready_o) |=> $stable(data_i)
  ) else $error("DMA request changed while stalled");

endmodule : dma_spill_register

`default_nettype wire

//--- group_dma_engine.sv
/*
 * Per-group DMA backend model. Counts the beats of each transfer and reports
 * an unregistered status word; takes one request at a time while idle.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cluster_config.svh"

module group_dma_engine (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire dma_pkg::dma_req_t dma_req_i,
  input  wire logic              dma_req_valid_i,
  output logic                   dma_req_ready_o,
  output dma_pkg::dma_meta_t     dma_meta_o
);

  localparam logic [`DMA_LEN_W:0] BEAT_BYTES = `DMA_BEAT_BYTES;
  localparam logic [`DMA_LEN_W:0] BEAT_ROUND = `DMA_BEAT_BYTES - 1;

  dma_pkg::dma_state_e   state_q;
  dma_pkg::dma_state_e   state_d;
  logic [`DMA_LEN_W-1:0] beat_cnt_q;
  logic [`DMA_LEN_W-1:0] beat_cnt_d;
  logic [`DMA_LEN_W:0]   len_round;
  logic [`DMA_LEN_W:0]   num_beats;
  logic                  req_fire;

  assign dma_req_ready_o = (state_q == dma_pkg::DMA_IDLE);
  assign req_fire        = dma_req_valid_i && dma_req_ready_o;

  // Round the byte count up to whole beats
  assign len_round = {1'b0, dma_req_i.num_bytes} + BEAT_ROUND;
  assign num_beats = len_round / BEAT_BYTES;

  always_comb begin
    state_d    = state_q;
    beat_cnt_d = beat_cnt_q;
    case (state_q)
      dma_pkg::DMA_IDLE: begin
        if (req_fire) begin
          state_d    = dma_pkg::DMA_BUSY;
          beat_cnt_d = num_beats[`DMA_LEN_W-1:0];
        end
      end
      dma_pkg::DMA_BUSY: begin
        // Count every beat down, then one closing cycle at zero
        if (beat_cnt_q == '0) begin
          state_d = dma_pkg::DMA_DONE;
        end else begin
          beat_cnt_d = beat_cnt_q - 1'b1;
        end
      end
      dma_pkg::DMA_DONE: begin
        state_d = dma_pkg::DMA_IDLE;
      end
      default: begin
        state_d = dma_pkg::DMA_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= dma_pkg::DMA_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q    <= state_d;
      beat_cnt_q <= beat_cnt_d;
    end
  end

  assign dma_meta_o.backend_idle   = (state_q == dma_pkg::DMA_IDLE);
  assign dma_meta_o.trans_complete = (state_q == dma_pkg::DMA_DONE);

  a_nonzero_len: assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_fire |-> (dma_req_i.num_bytes != '0)
  ) else $error("DMA request with zero length accepted");

  a_meta_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(dma_meta_o.backend_idle && dma_meta_o.trans_complete)
  ) else $error("DMA status shows idle and complete together");

endmodule : group_dma_engine

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cluster testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_terapool_cluster \
  -f terapool_cluster.f -o tb_terapool_cluster \
  || { echo "Build failed"; exit 1; }
sim_out="$(./obj_dir/tb_terapool_cluster)"
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && echo "Result: PASS" \
  || { echo "Result: FAIL"; exit 1; }

//--- tb_terapool_cluster.sv
/*
 * Self-checking testbench for the cluster control and DMA front end.
 * Applies a stimulus table per group, then all-group and back-pressure tests.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cluster_config.svh"

module tb_terapool_cluster;

  localparam int NUM_GROUPS = `NUM_GROUPS;
  localparam int WAKE_W     = `NUM_GROUPS * `NUM_CORES_PER_GROUP;
  localparam int NUM_ROWS   = 6;
  localparam int BP_REQS    = 4;

  typedef logic [`DMA_LEN_W-1:0] len_t;

  // One row drives one group's request and the shared control lines
  typedef struct packed {
    int                          group_idx;
    len_t                        num_bytes;
    logic [WAKE_W-1:0]           wake;
    cluster_pkg::ro_cache_ctrl_t cache;
  } stim_row_t;

  logic                                         clk_i;
  logic                                         rst_i;
  logic [WAKE_W-1:0]                            wake_up_i;
  cluster_pkg::ro_cache_ctrl_t                  ro_cache_ctrl_i;
  dma_pkg::dma_req_t [NUM_GROUPS-1:0]           dma_req_i;
  logic [NUM_GROUPS-1:0]                        dma_req_valid_i;
  logic [NUM_GROUPS-1:0]                        dma_req_ready_o;
  dma_pkg::dma_meta_t [NUM_GROUPS-1:0]          dma_meta_o;
  logic [WAKE_W-1:0]                            wake_up_o;
  cluster_pkg::ro_cache_ctrl_t [NUM_GROUPS-1:0] ro_cache_ctrl_o;

  stim_row_t stim [NUM_ROWS];
  len_t      bp_bytes [BP_REQS];
  len_t      indep_bytes [NUM_GROUPS];

  // Expected transfer per group while watching the status words
  int        watch_k [NUM_GROUPS];
  len_t      watch_bytes [NUM_GROUPS];
  bit        watch_active [NUM_GROUPS];

  logic [WAKE_W-1:0]           prev_wake;
  cluster_pkg::ro_cache_ctrl_t prev_cache;

  integer seed   = 32'hab398ef4;
  int     cyc    = 0;
  int     checks = 0;
  int     errors = 0;

  terapool_cluster DUT (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wake_up_i       (wake_up_i),
    .ro_cache_ctrl_i (ro_cache_ctrl_i),
    .dma_req_i       (dma_req_i),
    .dma_req_valid_i (dma_req_valid_i),
    .dma_req_ready_o (dma_req_ready_o),
    .dma_meta_o      (dma_meta_o),
    .wake_up_o       (wake_up_o),
    .ro_cache_ctrl_o (ro_cache_ctrl_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Number of the last rising edge, read at the falling edge
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  function automatic void load_table();
    // group, num_bytes, wake-up, {enable, flush}
    stim[0] = '{0, 16'd1,  16'h0001, 2'b11};
    stim[1] = '{1, 16'd4,  16'h00f0, 2'b00};
    stim[2] = '{2, 16'd5,  16'h0f00, 2'b10};
    stim[3] = '{3, 16'd64, 16'hf000, 2'b01};
    stim[4] = '{1, 16'd13, 16'ha5c3, 2'b11};
    stim[5] = '{2, 16'd2,  16'hffff, 2'b10};
    bp_bytes[0]    = 16'd64;
    bp_bytes[1]    = 16'd8;
    bp_bytes[2]    = 16'd12;
    bp_bytes[3]    = 16'd20;
    indep_bytes[0] = 16'd20;
    indep_bytes[1] = 16'd7;
    indep_bytes[2] = 16'd33;
    indep_bytes[3] = 16'd2;
  endfunction

  // Whole beats per transfer, rounded up
  function automatic int beats(input int n);
    return (n + `DMA_BEAT_BYTES - 1) / `DMA_BEAT_BYTES;
  endfunction

  // Engine phase seen on the registered status at edge e
  function automatic dma_pkg::dma_state_e expected_phase(input int g, input int e);
    int                  done_edge;
    dma_pkg::dma_state_e ph;
    done_edge = watch_k[g] + beats(int'(watch_bytes[g])) + 3;
    if (!watch_active[g] || e < watch_k[g] + 2 || e > done_edge) begin
      ph = dma_pkg::DMA_IDLE;
    end else if (e == done_edge) begin
      ph = dma_pkg::DMA_DONE;
    end else begin
      ph = dma_pkg::DMA_BUSY;
    end
    return ph;
  endfunction

  function automatic int run_budget_ns();
    int cycles;
    cycles = 20;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycles += beats(int'(stim[r].num_bytes)) + 8;
    end
    for (int i = 0; i < BP_REQS; i++) begin
      cycles += beats(int'(bp_bytes[i])) + 8;
    end
    for (int g = 0; g < NUM_GROUPS; g++) begin
      cycles += beats(int'(indep_bytes[g])) + 8;
    end
    return cycles * 4 + 200;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_controls(input string tag, input logic [WAKE_W-1:0] wake,
                                input cluster_pkg::ro_cache_ctrl_t cache);
    check_value({tag, " wake_up_o"}, 32'(wake), 32'(wake_up_o));
    for (int g = 0; g < NUM_GROUPS; g++) begin
      check_value($sformatf("%s ro_cache_ctrl_o[%0d]", tag, g), 32'(cache),
                  32'(ro_cache_ctrl_o[g]));
    end
  endtask

  task automatic drive_request(input int g, input len_t nbytes);
    dma_req_i[g].src_addr  = $random(seed);
    dma_req_i[g].dst_addr  = $random(seed);
    dma_req_i[g].num_bytes = nbytes;
    dma_req_valid_i[g]     = 1'b1;
  endtask

  // Called at a falling edge with valid high
  task automatic wait_ready(input int g, output int accept_edge);
    int tries;
    tries = 0;
    while (!dma_req_ready_o[g] && tries < 200) begin
      @(negedge clk_i);
      tries++;
    end
    if (!dma_req_ready_o[g]) begin
      report_fault($sformatf("group %0d never raised dma_req_ready_o", g));
    end
    accept_edge = cyc + 1;
  endtask

  task automatic watch_groups(input string tag, input int last_edge);
    dma_pkg::dma_state_e ph;
    int                  e;
    e = 0;
    while (e < last_edge) begin
      @(negedge clk_i);
      e = cyc;
      for (int g = 0; g < NUM_GROUPS; g++) begin
        ph = expected_phase(g, e);
        check_value($sformatf("%s g%0d edge %0d %s backend_idle", tag, g, e, ph.name()),
                    32'(ph == dma_pkg::DMA_IDLE), 32'(dma_meta_o[g].backend_idle));
        check_value($sformatf("%s g%0d edge %0d %s trans_complete", tag, g, e, ph.name()),
                    32'(ph == dma_pkg::DMA_DONE), 32'(dma_meta_o[g].trans_complete));
      end
    end
  endtask

  task automatic check_reset_state();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_controls("reset", '0, cluster_pkg::ro_cache_ctrl_default);
    for (int g = 0; g < NUM_GROUPS; g++) begin
      check_value($sformatf("reset ready g%0d", g), 32'd1, 32'(dma_req_ready_o[g]));
      check_value($sformatf("reset meta g%0d", g), 32'b10, 32'(dma_meta_o[g]));
    end
  endtask

  task automatic run_row(input int r);
    stim_row_t row;
    string     tag;
    int        g;
    int        k;
    row = stim[r];
    g   = row.group_idx;
    tag = $sformatf("row%0d", r);
    @(posedge clk_i);
    #1;
    wake_up_i       = row.wake;
    ro_cache_ctrl_i = row.cache;
    drive_request(g, row.num_bytes);
    @(negedge clk_i);
    // Edge registers have not captured the new values yet
    check_controls({tag, " before"}, prev_wake, prev_cache);
    wait_ready(g, k);
    @(posedge clk_i);
    #1;
    dma_req_valid_i[g] = 1'b0;
    @(negedge clk_i);
    check_controls({tag, " after"}, row.wake, row.cache);
    for (int i = 0; i < NUM_GROUPS; i++) begin
      watch_active[i] = 1'b0;
    end
    watch_k[g]      = k;
    watch_bytes[g]  = row.num_bytes;
    watch_active[g] = 1'b1;
    watch_groups(tag, k + beats(int'(row.num_bytes)) + 5);
    prev_wake  = row.wake;
    prev_cache = row.cache;
  endtask

  task automatic run_independence();
    int k;
    int last;
    @(posedge clk_i);
    #1;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      drive_request(g, indep_bytes[g]);
    end
    @(negedge clk_i);
    k    = cyc + 1;
    last = k;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      check_value($sformatf("indep ready g%0d", g), 32'd1, 32'(dma_req_ready_o[g]));
      watch_k[g]      = k;
      watch_bytes[g]  = indep_bytes[g];
      watch_active[g] = 1'b1;
      if (k + beats(int'(indep_bytes[g])) + 5 > last) begin
        last = k + beats(int'(indep_bytes[g])) + 5;
      end
    end
    @(posedge clk_i);
    #1;
    dma_req_valid_i = '0;
    watch_groups("indep", last);
  endtask

  // Long request on group 0, followed at once by more requests
  task automatic run_back_pressure();
    int pulse_q [$];
    int first_acc;
    int idx;
    int n;
    int limit;
    int first_done;
    int exp_done;
    bit stalled;
    bit holding;
    limit   = 0;
    stalled = 1'b0;
    for (int i = 0; i < BP_REQS; i++) begin
      limit += beats(int'(bp_bytes[i])) + 8;
    end
    @(posedge clk_i);
    #1;
    drive_request(0, bp_bytes[0]);
    @(negedge clk_i);
    wait_ready(0, first_acc);
    first_done = first_acc + beats(int'(bp_bytes[0])) + 3;
    idx = 1;
    while (idx < BP_REQS && !stalled) begin
      @(posedge clk_i);
      #1;
      drive_request(0, bp_bytes[idx]);
      @(negedge clk_i);
      if (dma_req_ready_o[0]) begin
        idx++;
      end else begin
        stalled = 1'b1;
      end
    end
    check_value("bp accepted before stall", 32'd3, idx);
    holding = stalled;
    n = 0;
    while (n < limit && (pulse_q.size() < BP_REQS || holding)) begin
      @(posedge clk_i);
      #1;
      if (!holding) begin
        dma_req_valid_i[0] = 1'b0;
      end
      @(negedge clk_i);
      n++;
      if (dma_meta_o[0].trans_complete) begin
        pulse_q.push_back(cyc);
      end
      if (holding && dma_req_ready_o[0]) begin
        holding = 1'b0;
        if (cyc < first_done) begin
          report_fault("dma_req_ready_o rose again before the first completion");
        end
      end
    end
    check_value("bp completion count", BP_REQS, pulse_q.size());
    // Next buffered request starts one edge after the engine is idle again
    exp_done = first_done;
    for (int i = 0; i < pulse_q.size() && i < BP_REQS; i++) begin
      if (i > 0) begin
        exp_done += beats(int'(bp_bytes[i])) + 3;
      end
      check_value($sformatf("bp completion %0d edge", i), exp_done, pulse_q[i]);
    end
  endtask

  initial begin
    load_table();
    rst_i           = 1'b1;
    wake_up_i       = '0;
    ro_cache_ctrl_i = cluster_pkg::ro_cache_ctrl_default;
    dma_req_i       = '0;
    dma_req_valid_i = '0;
    prev_wake       = '0;
    prev_cache      = cluster_pkg::ro_cache_ctrl_default;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_reset_state();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    run_independence();
    run_back_pressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Budget follows the lengths of all transfers in the run
  initial begin
    int budget_ns;
    #1;
    budget_ns = run_budget_ns();
    #(budget_ns);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", budget_ns + 1);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("sim failed");
    $finish;
  end

endmodule : tb_terapool_cluster

`default_nettype wire

//--- terapool_cluster.f
+incdir+.
cluster_pkg.sv
dma_pkg.sv
dma_spill_register.sv
group_dma_engine.sv
cluster_ctrl_sync.sv
terapool_cluster.sv
tb_terapool_cluster.sv

//--- terapool_cluster.sv
/*
 * Control and DMA front end of the cluster. Registers the control lines once
 * at the edge and feeds each group's DMA engine through a spill register.
 */

`timescale 1ns/100ps
`default_nettype none

`include "cluster_config.svh"

module terapool_cluster (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_i,
  input  wire logic [`NUM_GROUPS*`NUM_CORES_PER_GROUP-1:0]   wake_up_i,
  input  wire cluster_pkg::ro_cache_ctrl_t                   ro_cache_ctrl_i,
  input  wire dma_pkg::dma_req_t [`NUM_GROUPS-1:0]           dma_req_i,
  input  wire logic [`NUM_GROUPS-1:0]                        dma_req_valid_i,
  output logic [`NUM_GROUPS-1:0]                             dma_req_ready_o,
  output dma_pkg::dma_meta_t [`NUM_GROUPS-1:0]               dma_meta_o,
  output logic [`NUM_GROUPS*`NUM_CORES_PER_GROUP-1:0]        wake_up_o,
  output cluster_pkg::ro_cache_ctrl_t [`NUM_GROUPS-1:0]      ro_cache_ctrl_o
);

  // Spill register to engine, per group
  dma_pkg::dma_req_t  [`NUM_GROUPS-1:0] dma_req_group_q;
  logic               [`NUM_GROUPS-1:0] dma_req_group_q_valid;
  logic               [`NUM_GROUPS-1:0] dma_req_group_q_ready;
  dma_pkg::dma_meta_t [`NUM_GROUPS-1:0] dma_meta;

  cluster_ctrl_sync i_ctrl_sync (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wake_up_i       (wake_up_i),
    .ro_cache_ctrl_i (ro_cache_ctrl_i),
    .dma_meta_i      (dma_meta),
    .wake_up_o       (wake_up_o),
    .ro_cache_ctrl_o (ro_cache_ctrl_o),
    .dma_meta_o      (dma_meta_o)
  );

  for (genvar g = 0; g < `NUM_GROUPS; g++) begin : gen_group
    dma_spill_register i_dma_spill (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (dma_req_i[g]),
      .valid_i (dma_req_valid_i[g]),
      .ready_o (dma_req_ready_o[g]),
      .data_o  (dma_req_group_q[g]),
      .valid_o (dma_req_group_q_valid[g]),
      .ready_i (dma_req_group_q_ready[g])
    );

    group_dma_engine i_dma_engine (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .dma_req_i       (dma_req_group_q[g]),
      .dma_req_valid_i (dma_req_group_q_valid[g]),
      .dma_req_ready_o (dma_req_group_q_ready[g]),
      .dma_meta_o      (dma_meta[g])
    );
  end : gen_group

endmodule : terapool_cluster

`default_nettype wire
